/* ecc_cfg.svh */
`ifndef ECC_CFG_SVH
`define ECC_CFG_SVH

// field word width
`define ECC_W 32

// key bits after the implicit leading 1
`define ECC_KEY_STEPS 4

// microprogram lengths
`define ECC_DBL_STEPS 12
`define ECC_ADD_STEPS 9

`endif

/* ecc_pkg.sv */
`include "ecc_cfg.svh"

package ecc_pkg;

    typedef logic [`ECC_W-1:0] field_t;

    typedef struct packed {
        field_t x;
        field_t y;
    } point_t;

    // encoding as seen by the field unit
    typedef enum logic [1:0] {
        FOP_ADD = 2'd0,
        FOP_SUB = 2'd1,
        FOP_MUL = 2'd2,
        FOP_DIV = 2'd3   // opa / opb
    } fop_e;

    typedef struct packed {
        fop_e   op;
        field_t opa;
        field_t opb;
    } fop_cmd_t;

    typedef enum logic [2:0] {
        SRC_R1,
        SRC_R2,
        SRC_ACC_X,
        SRC_ACC_Y,
        SRC_BASE_X,
        SRC_BASE_Y,
        SRC_RES_X,
        SRC_CURVE_A
    } src_e;

    typedef enum logic [1:0] {
        DST_R1,
        DST_R2,
        DST_RES_X_R2,   // x3 and r2 together
        DST_RES_Y
    } dst_e;

    typedef struct packed {
        fop_e op;
        src_e src_a;
        src_e src_b;
        dst_e dst;
    } step_t;

endpackage

/* ecc_step_rom.sv */
`timescale 1ns/1ps

module ecc_step_rom (
    input  logic [4:0]     i_step_idx,
    output ecc_pkg::step_t o_step
);

    always_comb
    begin
        case (i_step_idx)
            // doubling, slope = (3*x1^2 + a) / 2*y1
            5'd0:  o_step = '{ecc_pkg::FOP_MUL, ecc_pkg::SRC_ACC_X, ecc_pkg::SRC_ACC_X,
                             ecc_pkg::DST_R1};         // x1^2
            5'd1:  o_step = '{ecc_pkg::FOP_ADD, ecc_pkg::SRC_R1, ecc_pkg::SRC_R1,
                             ecc_pkg::DST_R2};
            5'd2:  o_step = '{ecc_pkg::FOP_ADD, ecc_pkg::SRC_R1, ecc_pkg::SRC_R2,
                             ecc_pkg::DST_R1};         // 3*x1^2
            5'd3:  o_step = '{ecc_pkg::FOP_ADD, ecc_pkg::SRC_R1, ecc_pkg::SRC_CURVE_A,
                             ecc_pkg::DST_R1};
            5'd4:  o_step = '{ecc_pkg::FOP_ADD, ecc_pkg::SRC_ACC_Y, ecc_pkg::SRC_ACC_Y,
                             ecc_pkg::DST_R2};         // 2*y1
            5'd5:  o_step = '{ecc_pkg::FOP_DIV, ecc_pkg::SRC_R1, ecc_pkg::SRC_R2,
                             ecc_pkg::DST_R1};         // slope
            5'd6:  o_step = '{ecc_pkg::FOP_MUL, ecc_pkg::SRC_R1, ecc_pkg::SRC_R1,
                             ecc_pkg::DST_R2};
            5'd7:  o_step = '{ecc_pkg::FOP_SUB, ecc_pkg::SRC_R2, ecc_pkg::SRC_ACC_X,
                             ecc_pkg::DST_R2};
            5'd8:  o_step = '{ecc_pkg::FOP_SUB, ecc_pkg::SRC_R2, ecc_pkg::SRC_ACC_X,
                             ecc_pkg::DST_RES_X_R2};   // x3
            5'd9:  o_step = '{ecc_pkg::FOP_SUB, ecc_pkg::SRC_ACC_X, ecc_pkg::SRC_RES_X,
                             ecc_pkg::DST_R2};
            5'd10: o_step = '{ecc_pkg::FOP_MUL, ecc_pkg::SRC_R1, ecc_pkg::SRC_R2,
                             ecc_pkg::DST_R2};
            5'd11: o_step = '{ecc_pkg::FOP_SUB, ecc_pkg::SRC_R2, ecc_pkg::SRC_ACC_Y,
                             ecc_pkg::DST_RES_Y};      // y3
            // addition, slope = (y2 - y1) / (x2 - x1)
            5'd12: o_step = '{ecc_pkg::FOP_SUB, ecc_pkg::SRC_BASE_X, ecc_pkg::SRC_ACC_X,
                             ecc_pkg::DST_R1};
            5'd13: o_step = '{ecc_pkg::FOP_SUB, ecc_pkg::SRC_BASE_Y, ecc_pkg::SRC_ACC_Y,
                             ecc_pkg::DST_R2};
            5'd14: o_step = '{ecc_pkg::FOP_DIV, ecc_pkg::SRC_R2, ecc_pkg::SRC_R1,
                             ecc_pkg::DST_R1};         // slope
            5'd15: o_step = '{ecc_pkg::FOP_MUL, ecc_pkg::SRC_R1, ecc_pkg::SRC_R1,
                             ecc_pkg::DST_R2};
            5'd16: o_step = '{ecc_pkg::FOP_SUB, ecc_pkg::SRC_R2, ecc_pkg::SRC_ACC_X,
                             ecc_pkg::DST_R2};
            5'd17: o_step = '{ecc_pkg::FOP_SUB, ecc_pkg::SRC_R2, ecc_pkg::SRC_BASE_X,
                             ecc_pkg::DST_RES_X_R2};   // x3
            5'd18: o_step = '{ecc_pkg::FOP_SUB, ecc_pkg::SRC_ACC_X, ecc_pkg::SRC_RES_X,
                             ecc_pkg::DST_R2};
            5'd19: o_step = '{ecc_pkg::FOP_MUL, ecc_pkg::SRC_R1, ecc_pkg::SRC_R2,
                             ecc_pkg::DST_R2};
            5'd20: o_step = '{ecc_pkg::FOP_SUB, ecc_pkg::SRC_R2, ecc_pkg::SRC_ACC_Y,
                             ecc_pkg::DST_RES_Y};      // y3
            default:
                o_step = '0;   // never addressed
        endcase
    end

endmodule

/* ecc_sequencer.sv */
`timescale 1ns/1ps
`include "ecc_cfg.svh"

module ecc_sequencer (
    input  logic       i_clk,
    input  logic       i_reset,
    input  logic       i_start,
    input  logic       i_bit_valid,
    input  logic       i_key_bit,
    input  logic       i_fop_done,
    output logic       o_bit_req,
    output logic       o_fop_valid,
    output logic [4:0] o_step_idx,
    output logic       o_acc_load,
    output logic       o_acc_from_result,
    output logic       o_busy,
    output logic       o_done
);

    localparam int ITER_W = $clog2(`ECC_KEY_STEPS + 1);
    localparam logic [4:0] DBL_LAST = 5'(`ECC_DBL_STEPS - 1);
    localparam logic [4:0] ADD_LAST = 5'(`ECC_DBL_STEPS + `ECC_ADD_STEPS - 1);
    localparam logic [ITER_W-1:0] ITER_LAST = ITER_W'(`ECC_KEY_STEPS - 1);

    typedef enum logic [2:0] {
        S_IDLE,
        S_BIT_REQ,
        S_BIT_WAIT,
        S_DOUBLE,
        S_ADD,
        S_FINISH
    } state_e;

    state_e            state;
    logic [4:0]        step_idx;
    logic [ITER_W-1:0] iter_cnt;
    logic              key_bit_q;
    logic              dbl_end;
    logic              add_end;
    logic              iter_end;

    assign dbl_end  = (state == S_DOUBLE) && i_fop_done && (step_idx == DBL_LAST);
    assign add_end  = (state == S_ADD) && i_fop_done && (step_idx == ADD_LAST);
    assign iter_end = (dbl_end && !key_bit_q) || add_end;

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            state     <= S_IDLE;
            step_idx  <= '0;
            iter_cnt  <= '0;
            key_bit_q <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                begin
                    if (i_start)
                    begin
                        iter_cnt <= '0;
                        state    <= S_BIT_REQ;
                    end
                end
                S_BIT_REQ:
                    state <= S_BIT_WAIT;
                S_BIT_WAIT:
                begin
                    if (i_bit_valid)
                    begin
                        key_bit_q <= i_key_bit;
                        step_idx  <= '0;
                        state     <= S_DOUBLE;
                    end
                end
                S_DOUBLE, S_ADD:
                begin
                    if (i_fop_done)
                        step_idx <= step_idx + 5'd1;   // D12 rolls into A1
                    if (dbl_end && key_bit_q)
                        state <= S_ADD;
                    if (iter_end)
                    begin
                        iter_cnt <= iter_cnt + 1'b1;
                        state    <= (iter_cnt == ITER_LAST) ? S_FINISH : S_BIT_REQ;
                    end
                end
                S_FINISH:
                    state <= S_IDLE;
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    assign o_bit_req   = (state == S_BIT_REQ);
    assign o_fop_valid = (state == S_DOUBLE) || (state == S_ADD);
    assign o_step_idx  = step_idx;

    // input point at start, result point after every phase
    assign o_acc_load        = ((state == S_IDLE) && i_start) || dbl_end || add_end;
    assign o_acc_from_result = (state != S_IDLE);

    assign o_busy = (state != S_IDLE) && (state != S_FINISH);
    assign o_done = (state == S_FINISH);

endmodule

/* ecc_point_regs.sv */
`timescale 1ns/1ps

module ecc_point_regs (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_start,
    input  ecc_pkg::point_t   i_point,
    input  ecc_pkg::field_t   i_curve_a,
    input  ecc_pkg::step_t    i_step,
    input  logic              i_acc_load,
    input  logic              i_acc_from_result,
    input  logic              i_fop_done,
    input  ecc_pkg::field_t   i_fop_result,
    output ecc_pkg::fop_cmd_t o_fop_cmd,
    output ecc_pkg::point_t   o_result
);

    ecc_pkg::field_t r1;
    ecc_pkg::field_t r2;
    ecc_pkg::field_t curve_a;
    ecc_pkg::point_t acc;       // x1, y1
    ecc_pkg::point_t base;      // x2, y2
    ecc_pkg::point_t res;       // x3, y3
    ecc_pkg::point_t res_nxt;
    ecc_pkg::field_t src_word [0:7];
    logic            run_start;

    // a start seen while running belongs to nobody
    assign run_start = i_start & ~i_acc_from_result;

    always_comb
    begin
        src_word[ecc_pkg::SRC_R1]      = r1;
        src_word[ecc_pkg::SRC_R2]      = r2;
        src_word[ecc_pkg::SRC_ACC_X]   = acc.x;
        src_word[ecc_pkg::SRC_ACC_Y]   = acc.y;
        src_word[ecc_pkg::SRC_BASE_X]  = base.x;
        src_word[ecc_pkg::SRC_BASE_Y]  = base.y;
        src_word[ecc_pkg::SRC_RES_X]   = res.x;
        src_word[ecc_pkg::SRC_CURVE_A] = curve_a;
    end

    assign o_fop_cmd = '{op:  i_step.op,
                         opa: src_word[i_step.src_a],
                         opb: src_word[i_step.src_b]};

    // result point including the write of this cycle, so the
    // accumulator can take y3 on the same edge as the last done
    always_comb
    begin
        res_nxt = res;
        if (i_fop_done && i_step.dst == ecc_pkg::DST_RES_X_R2)
            res_nxt.x = i_fop_result;
        if (i_fop_done && i_step.dst == ecc_pkg::DST_RES_Y)
            res_nxt.y = i_fop_result;
    end

    always_ff @(posedge i_clk)
    begin
        res <= res_nxt;
        if (i_fop_done)
        begin
            case (i_step.dst)
                ecc_pkg::DST_R1:
                    r1 <= i_fop_result;
                ecc_pkg::DST_R2, ecc_pkg::DST_RES_X_R2:
                    r2 <= i_fop_result;
                default:
                    r2 <= r2;   // y3 only
            endcase
        end
        if (run_start)
        begin
            base    <= i_point;
            curve_a <= i_curve_a;
        end
    end

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
            acc <= '0;
        else if (i_acc_load)
            acc <= i_acc_from_result ? res_nxt : i_point;
    end

    assign o_result = acc;

endmodule

/* ecc_point_mul.sv */
`timescale 1ns/1ps

module ecc_point_mul (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_start,
    input  ecc_pkg::point_t   i_point,
    input  ecc_pkg::field_t   i_curve_a,
    output logic              o_bit_req,
    input  logic              i_bit_valid,
    input  logic              i_key_bit,
    output logic              o_fop_valid,
    output ecc_pkg::fop_cmd_t o_fop_cmd,
    input  logic              i_fop_done,
    input  ecc_pkg::field_t   i_fop_result,
    output logic              o_busy,
    output logic              o_done,
    output ecc_pkg::point_t   o_result
);

    logic [4:0]     step_idx;
    ecc_pkg::step_t step;
    logic           acc_load;
    logic           acc_from_result;

    ecc_sequencer i_sequencer (
        .i_clk             (i_clk),
        .i_reset           (i_reset),
        .i_start           (i_start),
        .i_bit_valid       (i_bit_valid),
        .i_key_bit         (i_key_bit),
        .i_fop_done        (i_fop_done),
        .o_bit_req         (o_bit_req),
        .o_fop_valid       (o_fop_valid),
        .o_step_idx        (step_idx),
        .o_acc_load        (acc_load),
        .o_acc_from_result (acc_from_result),
        .o_busy            (o_busy),
        .o_done            (o_done)
    );

    ecc_step_rom i_step_rom (
        .i_step_idx (step_idx),
        .o_step     (step)
    );

    ecc_point_regs i_point_regs (
        .i_clk             (i_clk),
        .i_reset           (i_reset),
        .i_start           (i_start),
        .i_point           (i_point),
        .i_curve_a         (i_curve_a),
        .i_step            (step),
        .i_acc_load        (acc_load),
        .i_acc_from_result (acc_from_result),
        .i_fop_done        (i_fop_done),
        .i_fop_result      (i_fop_result),
        .o_fop_cmd         (o_fop_cmd),
        .o_result          (o_result)
    );

endmodule

/* tb_field_unit.sv */
`timescale 1ns/1ps

module tb_field_unit #(
    parameter longint PRIME = 10007
) (
    input  logic              i_clk,
    input  logic              i_reset,
    input  logic              i_valid,
    input  ecc_pkg::fop_cmd_t i_cmd,
    output logic              o_done,
    output ecc_pkg::field_t   o_result
);

    logic            done_q = 1'b0;
    logic            pending = 1'b0;
    ecc_pkg::field_t result_q = '0;
    int              wait_cnt;

    function automatic longint pow_mod(longint b, longint e);
        longint r;
        r = 1;
        while (e > 0)
        begin
            if (e % 2 == 1)
                r = (r * b) % PRIME;
            b = (b * b) % PRIME;
            e = e / 2;
        end
        return r;
    endfunction

    function automatic longint field_op(ecc_pkg::fop_cmd_t cmd);
        longint a;
        longint b;
        a = cmd.opa;
        b = cmd.opb;
        case (cmd.op)
            ecc_pkg::FOP_ADD: return (a + b) % PRIME;
            ecc_pkg::FOP_SUB: return (a + PRIME - b) % PRIME;
            ecc_pkg::FOP_MUL: return (a * b) % PRIME;
            default:          return (a * pow_mod(b, PRIME - 2)) % PRIME;   // b^(p-2) = 1/b
        endcase
    endfunction

    always @(negedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            done_q  <= 1'b0;
            pending <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;
            if (pending)
            begin
                if (wait_cnt == 0)
                begin
                    done_q  <= 1'b1;
                    pending <= 1'b0;
                end
                else
                    wait_cnt <= wait_cnt - 1;
            end
            else if (i_valid)
            begin
                result_q <= ecc_pkg::field_t'(field_op(i_cmd));
                wait_cnt <= $urandom_range(5, 0);   // 1 to 6 cycles
                pending  <= 1'b1;
            end
        end
    end

    assign o_done   = done_q;
    assign o_result = result_q;

endmodule

/* ecc_point_mul_sva.sv */
`timescale 1ns/1ps

module ecc_point_mul_sva (
    input logic              i_clk,
    input logic              i_reset,
    input logic              i_fop_valid,
    input ecc_pkg::fop_cmd_t i_fop_cmd,
    input logic              i_fop_done,
    input logic              i_bit_req,
    input logic              i_busy,
    input logic              i_done
);

    cmd_stable: assert property (@(posedge i_clk) disable iff (i_reset)
        i_fop_valid && !i_fop_done |=> $stable(i_fop_cmd))
        else $error("field command changed while waiting for done");

    done_single: assert property (@(posedge i_clk) disable iff (i_reset)
        i_done |=> !i_done)
        else $error("o_done high for more than one cycle");

    done_with_busy: assert property (@(posedge i_clk) disable iff (i_reset)
        i_done |-> !i_busy && $past(i_busy))
        else $error("o_done not aligned with o_busy falling");

    no_bit_req_in_op: assert property (@(posedge i_clk) disable iff (i_reset)
        !(i_bit_req && i_fop_valid))
        else $error("key bit requested during a field operation");

endmodule

bind ecc_point_mul ecc_point_mul_sva i_sva (
    .i_clk       (i_clk),
    .i_reset     (i_reset),
    .i_fop_valid (o_fop_valid),
    .i_fop_cmd   (o_fop_cmd),
    .i_fop_done  (i_fop_done),
    .i_bit_req   (o_bit_req),
    .i_busy      (o_busy),
    .i_done      (o_done)
);

/* tb_ecc_point_mul.sv */
`timescale 1ns/1ps
`include "ecc_cfg.svh"

module tb_ecc_point_mul;

    localparam longint PRIME = 10007;
    localparam int ROWS = 5;
    localparam int CYCLE_LIMIT = ROWS * `ECC_KEY_STEPS * 21 * 8 + 400;

    typedef struct packed {
        ecc_pkg::point_t           point;
        ecc_pkg::field_t           curve_a;
        logic [`ECC_KEY_STEPS-1:0] key;
        logic                      extra_start;   // second start while busy
        ecc_pkg::point_t           expect_pt;
    } vec_t;

    logic              clk;
    logic              reset;
    logic              start;
    ecc_pkg::point_t   point;
    ecc_pkg::field_t   curve_a;
    logic              bit_req;
    logic              bit_valid = 1'b0;
    logic              key_bit = 1'b0;
    logic              fop_valid;
    ecc_pkg::fop_cmd_t fop_cmd;
    logic              fop_done;
    ecc_pkg::field_t   fop_result;
    logic              busy;
    logic              done;
    ecc_pkg::point_t   result;

    vec_t vec [ROWS];
    vec_t cur;
    int   cmd_cnt;
    int   done_cnt;
    int   cycle_cnt;
    int   bits_sent;
    int   bit_delay;
    bit   bit_pending;

    ecc_point_mul i_dut (
        .i_clk        (clk),
        .i_reset      (reset),
        .i_start      (start),
        .i_point      (point),
        .i_curve_a    (curve_a),
        .o_bit_req    (bit_req),
        .i_bit_valid  (bit_valid),
        .i_key_bit    (key_bit),
        .o_fop_valid  (fop_valid),
        .o_fop_cmd    (fop_cmd),
        .i_fop_done   (fop_done),
        .i_fop_result (fop_result),
        .o_busy       (busy),
        .o_done       (done),
        .o_result     (result)
    );

    tb_field_unit #(.PRIME(PRIME)) i_field_unit (
        .i_clk    (clk),
        .i_reset  (reset),
        .i_valid  (fop_valid),
        .i_cmd    (fop_cmd),
        .o_done   (fop_done),
        .o_result (fop_result)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "run stopped");
    endtask

    task automatic check_equal(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp)
        begin
            $display("FAIL at %0t: %s: got %0d, expected %0d", $time, what, got, exp);
            $display("TEST FAIL");
            $fatal(1, "mismatch");
        end
    endtask

    always @(posedge clk)
    begin
        cycle_cnt <= cycle_cnt + 1;
        if (fop_valid && fop_done)
            cmd_cnt <= cmd_cnt + 1;
        if (done)
            done_cnt <= done_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT)
        begin
            $display("timeout: the runs did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TEST FAIL");
            $fatal(1, "timeout");
        end
    end

    // key shifter, msb first, random answer delay
    always @(negedge clk)
    begin
        bit_valid <= 1'b0;
        if (!busy)
            bits_sent <= 0;
        if (bit_req)
        begin
            bit_delay   <= $urandom_range(3, 0);
            bit_pending <= 1'b1;
        end
        else if (bit_pending)
        begin
            if (bit_delay == 0)
            begin
                bit_valid   <= 1'b1;
                key_bit     <= cur.key[`ECC_KEY_STEPS - 1 - bits_sent];
                bits_sent   <= bits_sent + 1;
                bit_pending <= 1'b0;
            end
            else
                bit_delay <= bit_delay - 1;
        end
    end

    function automatic longint mul_mod(longint a, longint b);
        return (a * b) % PRIME;
    endfunction

    function automatic longint inv_mod(longint a);
        longint r;
        r = 1;
        for (longint i = 0; i < PRIME - 2; i++)   // a^(p-2)
            r = mul_mod(r, a);
        return r;
    endfunction

    task automatic ref_double(inout longint x, inout longint y, input longint a);
        longint s;
        longint x3;
        if (y == 0)
            abort_run("reference model: doubling a point with y = 0");
        s  = mul_mod((3 * mul_mod(x, x) + a) % PRIME, inv_mod((2 * y) % PRIME));
        x3 = (mul_mod(s, s) + 2 * PRIME - 2 * x) % PRIME;
        y  = (mul_mod(s, (x + PRIME - x3) % PRIME) + PRIME - y) % PRIME;
        x  = x3;
    endtask

    task automatic ref_add(inout longint x, inout longint y, input longint x2, input longint y2);
        longint s;
        longint x3;
        if (x == x2)
            abort_run("reference model: adding two points with the same x");
        s  = mul_mod((y2 + PRIME - y) % PRIME, inv_mod((x2 + PRIME - x) % PRIME));
        x3 = (mul_mod(s, s) + 2 * PRIME - x - x2) % PRIME;
        y  = (mul_mod(s, (x + PRIME - x3) % PRIME) + PRIME - y) % PRIME;
        x  = x3;
    endtask

    task automatic expected_point(inout vec_t v);
        longint x;
        longint y;
        x = v.point.x;
        y = v.point.y;
        for (int i = `ECC_KEY_STEPS - 1; i >= 0; i--)
        begin
            ref_double(x, y, v.curve_a);
            if (v.key[i])
                ref_add(x, y, v.point.x, v.point.y);
        end
        v.expect_pt.x = ecc_pkg::field_t'(x);
        v.expect_pt.y = ecc_pkg::field_t'(y);
    endtask

    task automatic run_row(input int r);
        int cmd_base;
        int ones;
        cur      = vec[r];
        cmd_base = cmd_cnt;
        ones     = $countones(cur.key);
        @(negedge clk);
        start   = 1'b1;
        point   = cur.point;
        curve_a = cur.curve_a;
        @(negedge clk);
        start = 1'b0;
        point = '0;
        while (!fop_valid)
            @(negedge clk);
        check_equal("first opcode", fop_cmd.op, ecc_pkg::FOP_MUL);
        check_equal("first opa", fop_cmd.opa, cur.point.x);
        check_equal("first opb", fop_cmd.opb, cur.point.x);
        if (cur.extra_start)
        begin
            while (cmd_cnt - cmd_base < 5)
                @(negedge clk);
            start   = 1'b1;   // must be ignored
            point   = ~cur.point;
            curve_a = ~cur.curve_a;
            @(negedge clk);
            start = 1'b0;
        end
        while (!done)
            @(negedge clk);
        check_equal("result x", result.x, cur.expect_pt.x);
        check_equal("result y", result.y, cur.expect_pt.y);
        check_equal("field commands", cmd_cnt - cmd_base, 12 * `ECC_KEY_STEPS + 9 * ones);
        check_equal("busy with done", busy, 0);
        @(negedge clk);
        check_equal("done pulses", done_cnt, r + 1);
    endtask

    initial
    begin
        void'($urandom(32'hbd74_0e38));
        reset   = 1'b1;
        start   = 1'b0;
        point   = '0;
        curve_a = '0;
        vec[0] = '{'{32'd1234, 32'd5678}, 32'd3, 4'b0000, 1'b0, '0};
        vec[1] = '{'{32'd4321, 32'd987}, 32'd7, 4'b1011, 1'b0, '0};
        vec[2] = '{'{32'd2024, 32'd7777}, 32'd0, 4'b1111, 1'b1, '0};
        vec[3] = '{'{32'd9001, 32'd333}, 32'd10006, 4'b0110, 1'b0, '0};
        vec[4] = '{'{32'd55, 32'd8888}, 32'd12, 4'b1000, 1'b1, '0};
        for (int r = 0; r < ROWS; r++)
            expected_point(vec[r]);
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        repeat (3)
        begin
            @(negedge clk);
            check_equal("outputs after reset", {busy, done, bit_req, fop_valid}, 0);
        end
        for (int r = 0; r < ROWS; r++)
            run_row(r);
        $display("TEST PASS");
        $finish;
    end

endmodule

/* sim.f */
+incdir+.
ecc_pkg.sv
ecc_step_rom.sv
ecc_sequencer.sv
ecc_point_regs.sv
ecc_point_mul.sv
tb_field_unit.sv
ecc_point_mul_sva.sv
tb_ecc_point_mul.sv

/* Bender.yml */
package:
  name: ecc_point_mul

export_include_dirs:
  - .

sources:
  - ecc_pkg.sv
  - ecc_step_rom.sv
  - ecc_sequencer.sv
  - ecc_point_regs.sv
  - ecc_point_mul.sv
  - target: test
    files:
      - tb_field_unit.sv
      - ecc_point_mul_sva.sv
      - tb_ecc_point_mul.sv
